// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

verilator --binary --timing --assert --top-module tb_core -Mdir "$obj_dir" -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

"./$obj_dir/Vtb_core" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -qx "PASS: all tests" "$log_file"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

// File: testbench/core_patterns.txt
# I <byte addr> <instruction word>      S <addr> <strobe> <store data at its lane>
# H <pc expected while halt is high>    all values hex, text after the columns is ignored
I 0000 FF800093  # addi x1, x0, -8
I 0004 00500113  # addi x2, x0, 5
I 0008 002081B3  # add  x3, x1, x2
I 000C 10302023  # sw   x3, 0x100(x0)
I 0010 40110233  # sub  x4, x2, x1
I 0014 10402223  # sw   x4, 0x104(x0)
I 0018 0020A2B3  # slt  x5, x1, x2
I 001C 0020B333  # sltu x6, x1, x2
I 0020 10502423  # sw   x5, 0x108(x0)
I 0024 10602623  # sw   x6, 0x10c(x0)
I 0028 0F00C393  # xori x7, x1, 0xf0
I 002C 0023E433  # or   x8, x7, x2
I 0030 07C47493  # andi x9, x8, 0x7c
I 0034 10702823  # sw   x7, 0x110(x0)
I 0038 10802A23  # sw   x8, 0x114(x0)
I 003C 10902C23  # sw   x9, 0x118(x0)
I 0040 01C11513  # slli x10, x2, 28
I 0044 4020D593  # srai x11, x1, 2
I 0048 0020D633  # srl  x12, x1, x2
I 004C 10A02E23  # sw   x10, 0x11c(x0)
I 0050 12B02023  # sw   x11, 0x120(x0)
I 0054 12C02223  # sw   x12, 0x124(x0)
I 0058 00210463  # beq  x2, x2, +8   taken
I 005C 04068693  # addi x13, x13, 64 skipped
I 0060 00208463  # beq  x1, x2, +8   not taken
I 0064 00168693  # addi x13, x13, 1
I 0068 00209463  # bne  x1, x2, +8   taken
I 006C 04068693  # addi x13, x13, 64 skipped
I 0070 00211463  # bne  x2, x2, +8   not taken
I 0074 00268693  # addi x13, x13, 2
I 0078 0020C463  # blt  x1, x2, +8   taken
I 007C 04068693  # addi x13, x13, 64 skipped
I 0080 00114463  # blt  x2, x1, +8   not taken
I 0084 00468693  # addi x13, x13, 4
I 0088 00115463  # bge  x2, x1, +8   taken
I 008C 04068693  # addi x13, x13, 64 skipped
I 0090 0020D463  # bge  x1, x2, +8   not taken
I 0094 00868693  # addi x13, x13, 8
I 0098 00116463  # bltu x2, x1, +8   taken
I 009C 04068693  # addi x13, x13, 64 skipped
I 00A0 0020E463  # bltu x1, x2, +8   not taken
I 00A4 01068693  # addi x13, x13, 16
I 00A8 0020F463  # bgeu x1, x2, +8   taken
I 00AC 04068693  # addi x13, x13, 64 skipped
I 00B0 00117463  # bgeu x2, x1, +8   not taken
I 00B4 02068693  # addi x13, x13, 32
I 00B8 12D02423  # sw   x13, 0x128(x0)
I 00BC 00000000  # all-zero word, no-op
I 00C0 0080076F  # jal  x14, +8
I 00C4 10302023  # skipped store
I 00C8 12E02623  # sw   x14, 0x12c(x0)
I 00CC 011707E7  # jalr x15, 17(x14), bit 0 cleared
I 00D0 10302023  # skipped store
I 00D4 12F02823  # sw   x15, 0x130(x0)
I 00D8 80FF7837  # lui  x16, 0x80ff7
I 00DC 13002A23  # sw   x16, 0x134(x0)
I 00E0 00001897  # auipc x17, 0x1
I 00E4 13102C23  # sw   x17, 0x138(x0)
I 00E8 02A80813  # addi x16, x16, 0x2a
I 00EC 15000023  # sb   x16, 0x140(x0)
I 00F0 150000A3  # sb   x16, 0x141(x0)
I 00F4 15000123  # sb   x16, 0x142(x0)
I 00F8 150001A3  # sb   x16, 0x143(x0)
I 00FC 15001223  # sh   x16, 0x144(x0)
I 0100 15001323  # sh   x16, 0x146(x0)
I 0104 15002423  # sw   x16, 0x148(x0)
I 0108 14B00903  # lb   x18, 0x14b(x0)
I 010C 14B04983  # lbu  x19, 0x14b(x0)
I 0110 14900A03  # lb   x20, 0x149(x0)
I 0114 14A01A83  # lh   x21, 0x14a(x0)
I 0118 14A05B03  # lhu  x22, 0x14a(x0)
I 011C 14801B83  # lh   x23, 0x148(x0)
I 0120 14402C03  # lw   x24, 0x144(x0)
I 0124 14002C83  # lw   x25, 0x140(x0)
I 0128 15202823  # sw   x18, 0x150(x0)
I 012C 15302A23  # sw   x19, 0x154(x0)
I 0130 15402C23  # sw   x20, 0x158(x0)
I 0134 15502E23  # sw   x21, 0x15c(x0)
I 0138 17602023  # sw   x22, 0x160(x0)
I 013C 17702223  # sw   x23, 0x164(x0)
I 0140 17802423  # sw   x24, 0x168(x0)
I 0144 17902623  # sw   x25, 0x16c(x0)
I 0148 00000073  # ecall
I 014C 10302023  # never reached
S 100 f FFFFFFFD  # -8 + 5
S 104 f 0000000D  # 5 - (-8)
S 108 f 00000001  # slt
S 10C f 00000000  # sltu
S 110 f FFFFFF08  # xori
S 114 f FFFFFF0D  # or
S 118 f 0000000C  # andi
S 11C f 50000000  # slli
S 120 f FFFFFFFE  # srai
S 124 f 07FFFFFF  # srl
S 128 f 0000003F  # every not-taken bit, no taken path
S 12C f 000000C4  # jal link
S 130 f 000000D0  # jalr link
S 134 f 80FF7000  # lui
S 138 f 000010E0  # auipc
S 140 1 0000002A
S 141 2 00002A00
S 142 4 002A0000
S 143 8 2A000000
S 144 3 0000702A
S 146 c 702A0000
S 148 f 80FF702A
S 150 f FFFFFF80  # lb lane 3
S 154 f 00000080  # lbu lane 3
S 158 f 00000070  # lb lane 1
S 15C f FFFF80FF  # lh upper
S 160 f 000080FF  # lhu upper
S 164 f 0000702A  # lh lower
S 168 f 702A702A  # both sh merged
S 16C f 2A2A2A2A  # four sb merged
H 148

// File: testbench/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk; // free running, 50% duty

endmodule

// File: testbench/tb_core.sv
module tb_core;
  import rv_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 4;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  inst_t       inst;
  dmem_req_t   dmem_req;
  logic [31:0] load_data;
  logic        halt;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];

  dmem_req_t   exp_q [$]; // expected stores in program order
  logic [31:0] halt_pc;
  int          n_words;
  int          store_idx;
  bit          loaded;

  tb_clock #(.PERIOD(CLK_PERIOD)) clock_gen (
    .clk (clk)
  );

  rv_core UUT (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .inst      (inst),
    .dmem_req  (dmem_req),
    .load_data (load_data),
    .halt      (halt)
  );

  // fetch outside the 1 KB image reads as zero
  assign inst      = (pc[31:10] == '0) ? imem[pc[9:2]] : '0;
  assign load_data = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_req.wstrb[k])
          dmem[dmem_req.addr[9:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8];
      end
    end
  end

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic report_bad_line(input string line);
    $display("pattern file line not understood: %s", line);
    stop_on_error();
  endtask

  // I <addr> <word>, S <addr> <strobe> <data>, H <pc>
  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    dmem_req_t   req;
    fd = $fopen("testbench/core_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/core_patterns.txt for reading");
      stop_on_error();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0) begin
          rest = line.substr(1, line.len() - 1);
          case (line[0])
            "I": begin
              if ($sscanf(rest, "%h %h", a, b) != 2 || a[31:10] != '0 || a[1:0] != 2'b00)
                report_bad_line(line);
              else begin
                imem[a[9:2]] = b;
                n_words++;
              end
            end
            "S": begin
              if ($sscanf(rest, "%h %h %h", a, b, c) != 3)
                report_bad_line(line);
              else begin
                req.addr  = a;
                req.wstrb = b[3:0];
                req.wdata = c;
                exp_q.push_back(req);
              end
            end
            "H": begin
              if ($sscanf(rest, "%h", a) != 1)
                report_bad_line(line);
              else
                halt_pc = a;
            end
            8'h23, 8'h20, 8'h09, 8'h0a, 8'h0d: ; // comment or blank
            default: report_bad_line(line);
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // one store request per cycle against the next expected entry
  task automatic check_store();
    dmem_req_t   exp;
    logic [31:0] mask;
    if (dmem_req.wstrb != 4'b0000) begin
      if (store_idx >= exp_q.size()) begin
        $display("unexpected store to %h at %0t, beyond the expected sequence",
                 dmem_req.addr, $time);
        stop_on_error();
      end else begin
        exp  = exp_q[store_idx];
        mask = strobe_mask(exp.wstrb);
        check_value(dmem_req.addr, exp.addr, $sformatf("store %0d address", store_idx));
        check_value({28'b0, dmem_req.wstrb}, {28'b0, exp.wstrb},
                    $sformatf("store %0d strobe", store_idx));
        check_value(dmem_req.wdata & mask, exp.wdata & mask,
                    $sformatf("store %0d data", store_idx));
        store_idx++;
      end
    end
  endtask

  initial begin
    rst       <= 1'b1;
    loaded    = 1'b0;
    n_words   = 0;
    store_idx = 0;
    halt_pc   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0; // empty slots decode as no-ops
      dmem[i] <= '0;
    end
    read_patterns();
    loaded = 1'b1;

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_value(pc, 32'h0, "pc after reset");
    check_value({31'b0, halt}, 32'h0, "halt after reset");

    while (halt !== 1'b1) begin
      check_value({30'b0, pc[1:0]}, 32'h0, "pc word alignment");
      check_store();
      @(negedge clk);
    end

    check_value(pc, halt_pc, "pc at halt");
    check_store(); // ecall itself stores nothing
    check_value(store_idx, exp_q.size(), "stores seen before halt");

    // parked on ecall with memory quiet
    repeat (3) begin
      @(negedge clk);
      check_value({31'b0, halt}, 32'h1, "halt held");
      check_value(pc, halt_pc, "pc held at halt");
      check_value({28'b0, dmem_req.wstrb}, 32'h0, "strobe after halt");
    end

    $display("PASS: all tests");
    $finish;
  end

  // watchdog sized from the program length
  initial begin
    wait (loaded);
    #(CLK_PERIOD * (4 * n_words + 100 + RST_CYCLES));
    $display("timeout: halt never came within %0d cycles", 4 * n_words + 100);
    stop_on_error();
  end

endmodule

// File: verilog/rv_alu.sv
`include "rv_params.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::alu_op_e     op,
  output logic [`RV_XLEN-1:0] result,
  output logic                zero
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt; // sign fills from the top
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0); // beq/bne after sub

endmodule

// File: verilog/rv_core.sv
`include "rv_params.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] pc,
  input  rv_pkg::inst_t       inst,
  output rv_pkg::dmem_req_t   dmem_req,
  input  logic [`RV_XLEN-1:0] load_data,
  output logic                halt
);
  import rv_pkg::*;

  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                alu_zero;
  logic [`RV_XLEN-1:0] load_val;
  logic [`RV_XLEN-1:0] wb_data;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;
  logic [`RV_XLEN-1:0] pc_next;
  logic                cond_met;
  logic                taken;

  rv_decode u_decode (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (ctrl.rf_we),
    .rd       (ctrl.rd),
    .wdata    (wb_data),
    .rs1      (inst.r.rs1),
    .rs2      (inst.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = (ctrl.src_a == SRC_A_PC) ? pc : rs1_data;
  assign alu_b = (ctrl.src_b == SRC_B_IMM) ? imm : rs2_data;

  rv_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  rv_lsu u_lsu (
    .ctrl      (ctrl),
    .addr      (alu_result),
    .store_val (rs2_data),
    .load_data (load_data),
    .dmem_req  (dmem_req),
    .load_val  (load_val)
  );

  always_comb begin
    case (ctrl.br_cond)
      3'b000:         cond_met = alu_zero;       // beq
      3'b001:         cond_met = !alu_zero;      // bne
      3'b100, 3'b110: cond_met = alu_result[0];  // blt, bltu
      3'b101, 3'b111: cond_met = !alu_result[0]; // bge, bgeu
      default:        cond_met = 1'b0;
    endcase
  end

  assign taken     = ctrl.is_branch && cond_met;
  assign pc_plus4  = pc + `RV_INST_BYTES;
  assign pc_target = pc + imm;
  assign halt      = ctrl.halt;

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:  wb_data = alu_result;
      WB_IMM:  wb_data = imm;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = load_val;
    endcase
  end

  always_comb begin
    if (halt)
      pc_next = pc; // park on the ecall
    else if (ctrl.is_jalr)
      pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    else if (ctrl.is_jal || taken)
      pc_next = pc_target;
    else
      pc_next = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc <= `RV_RESET_PC;
    else
      pc <= pc_next;
  end

  // even immediates from decode plus the jalr mask keep the pc halfword aligned
  a_pc_even: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
    else $error("pc bit 0 set, pc=%h", pc);

endmodule

// File: verilog/rv_decode.sv
`include "rv_params.svh"

module rv_decode (
  input  rv_pkg::inst_t        inst,
  output rv_pkg::ctrl_t        ctrl,
  output logic [`RV_XLEN-1:0]  imm
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                legal;

  assign funct3 = inst.r.funct3;
  assign funct7 = inst.r.funct7;

  assign imm_i = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{(`RV_XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
  assign imm_j = {{(`RV_XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};
  assign imm_u = {inst.u.imm_31_12, 12'b0};

  always_comb begin
    ctrl  = '0;
    imm   = '0;
    legal = 1'b0;
    case (inst.r.opcode)
      OP_LUI: begin
        legal       = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = WB_IMM;
        imm         = imm_u;
      end
      OP_AUIPC: begin
        legal       = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.src_a  = SRC_A_PC;
        ctrl.src_b  = SRC_B_IMM;
        imm         = imm_u;
      end
      OP_JAL: begin
        legal       = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.is_jal = 1'b1;
        imm         = imm_j;
      end
      OP_JALR: begin
        legal        = (funct3 == 3'b000);
        ctrl.rf_we   = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.is_jalr = 1'b1;
        ctrl.src_b   = SRC_B_IMM;
        imm          = imm_i;
      end
      OP_BRANCH: begin
        legal          = (funct3[2:1] != 2'b01);
        ctrl.is_branch = 1'b1;
        ctrl.br_cond   = funct3;
        // eq/ne by subtraction, ordered compares by slt/sltu
        ctrl.alu_op    = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
        imm            = imm_b;
      end
      OP_LOAD: begin
        legal         = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        ctrl.rf_we    = 1'b1;
        ctrl.wb_sel   = WB_LOAD;
        ctrl.is_load  = 1'b1;
        ctrl.mem_size = funct3;
        ctrl.src_b    = SRC_B_IMM;
        imm           = imm_i;
      end
      OP_STORE: begin
        legal         = (funct3 inside {3'b000, 3'b001, 3'b010});
        ctrl.is_store = 1'b1;
        ctrl.mem_size = funct3;
        ctrl.src_b    = SRC_B_IMM;
        imm           = imm_s;
      end
      OP_IMM, OP_REG: begin
        ctrl.rf_we = 1'b1;
        if (inst.r.opcode == OP_IMM) begin
          ctrl.src_b = SRC_B_IMM;
          imm        = imm_i;
        end
        case (funct3)
          3'b000: ctrl.alu_op = (inst.r.opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: ctrl.alu_op = ALU_SLL;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b101: ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
        // funct7 only matters for shifts, and for add/sub on register ops
        if (funct3 == 3'b101)
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        else if (funct3 == 3'b001 || inst.r.opcode == OP_REG)
          legal = (funct7 == 7'b0000000) ||
                  (inst.r.opcode == OP_REG && funct3 == 3'b000 && funct7 == 7'b0100000);
        else
          legal = 1'b1;
      end
      OP_SYSTEM: begin
        legal     = (inst[31:7] == '0); // ecall only
        ctrl.halt = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    if (!legal) begin
      ctrl = '0; // no-op, pc still steps by 4
      imm  = '0;
    end else begin
      ctrl.rd    = ctrl.rf_we ? inst.r.rd : 5'd0;
      ctrl.rf_we = ctrl.rf_we && (inst.r.rd != 5'd0);
    end
  end

endmodule

// File: verilog/rv_lsu.sv
`include "rv_params.svh"

module rv_lsu (
  input  rv_pkg::ctrl_t       ctrl,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] store_val,
  input  logic [`RV_XLEN-1:0] load_data,
  output rv_pkg::dmem_req_t   dmem_req,
  output logic [`RV_XLEN-1:0] load_val
);

  logic [1:0]  lane;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign lane = addr[1:0];

  always_comb begin
    dmem_req.addr  = addr;
    dmem_req.wdata = store_val;
    dmem_req.wstrb = 4'b0000;
    if (ctrl.is_store) begin
      case (ctrl.mem_size[1:0])
        2'b00: begin // sb
          dmem_req.wdata = {{(`RV_XLEN-8){1'b0}}, store_val[7:0]} << {lane, 3'b000};
          dmem_req.wstrb = 4'b0001 << lane;
        end
        2'b01: begin // sh to the upper or lower half
          dmem_req.wdata = {{(`RV_XLEN-16){1'b0}}, store_val[15:0]} << {lane[1], 4'b0000};
          dmem_req.wstrb = lane[1] ? 4'b1100 : 4'b0011;
        end
        default: dmem_req.wstrb = 4'b1111;
      endcase
    end

    a_strb_legal: assert final (dmem_req.wstrb inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                                       4'b1000, 4'b0011, 4'b1100, 4'b1111})
      else $error("illegal write strobe %b", dmem_req.wstrb);
  end

  // lane pick for sub-word loads
  assign ld_byte = load_data[{lane, 3'b000} +: 8];
  assign ld_half = load_data[{lane[1], 4'b0000} +: 16];

  always_comb begin
    if (!ctrl.is_load) begin
      load_val = '0;
    end else begin
      case (ctrl.mem_size)
        3'b000:  load_val = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};   // lb
        3'b001:  load_val = {{(`RV_XLEN-16){ld_half[15]}}, ld_half}; // lh
        3'b100:  load_val = {{(`RV_XLEN-8){1'b0}}, ld_byte};
        3'b101:  load_val = {{(`RV_XLEN-16){1'b0}}, ld_half};
        default: load_val = load_data;
      endcase
    end
  end

endmodule

// File: verilog/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

`define RV_RESET_PC 32'h0000_0000

// pc step for sequential fetch
`define RV_INST_BYTES 4

`endif

// File: verilog/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011,
    OP_AUIPC  = 7'b0010111,
    OP_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic {
    SRC_A_RS1,
    SRC_A_PC
  } src_a_e;

  typedef enum logic {
    SRC_B_RS2,
    SRC_B_IMM
  } src_b_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_PC4,
    WB_LOAD
  } wb_sel_e;

  // one fetched word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      opcode_e    opcode;
    } b;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      opcode_e    opcode;
    } j;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      opcode_e     opcode;
    } u;
  } inst_t;

  typedef struct packed {
    alu_op_e    alu_op;
    src_a_e     src_a;
    src_b_e     src_b;
    wb_sel_e    wb_sel;
    logic       rf_we;
    logic [4:0] rd;
    logic       is_branch;
    logic [2:0] br_cond;  // funct3 of the branch
    logic       is_jal;
    logic       is_jalr;
    logic       is_load;
    logic       is_store;
    logic [2:0] mem_size; // funct3 of the load or store
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic [3:0]          wstrb;
  } dmem_req_t;

endpackage

// File: verilog/rv_regfile.sv
`include "rv_params.svh"

module rv_regfile (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              we,
  input  logic [$clog2(`RV_REG_COUNT)-1:0]  rd,
  input  logic [`RV_XLEN-1:0]               wdata,
  input  logic [$clog2(`RV_REG_COUNT)-1:0]  rs1,
  input  logic [$clog2(`RV_REG_COUNT)-1:0]  rs2,
  output logic [`RV_XLEN-1:0]               rs1_data,
  output logic [`RV_XLEN-1:0]               rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, writes show up next cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 must stay zero across every write the core issues
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
    else $error("x0 read back nonzero");

endmodule

// File: vlog.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv
